// File: filelist.f
rtl/mirror_pkg.sv
rtl/line_reverse.sv
rtl/line_delay.sv
rtl/line_compose.sv
rtl/mirror_regs.sv
rtl/mirror_top.sv
test/mirror_props.sv
test/mirror_tb.sv

// File: rtl/line_compose.sv
`timescale 1ns/1ps

module line_compose (
    input  logic                    clk,
    input  logic                    rst,
    input  mirror_pkg::pixel_t      fwd_pix,
    input  mirror_pkg::pixel_t      rev_pix,
    input  mirror_pkg::mirror_cfg_t cfg,
    output mirror_pkg::pixel_t      pix_out,
    output logic                    line_done
);

    logic [mirror_pkg::PTR_BITS-1:0] col;
    mirror_pkg::mirror_cfg_t         cfg_q;
    mirror_pkg::mirror_cfg_t         cfg_cur;
    logic                            take_rev;
    logic [15:0]                     sel_data;
    logic [15:0]                     swp_data;
    logic                            out_valid;
    logic [15:0]                     out_data;

    // Column 0 uses the live register so a new mode applies from the first beat
    assign cfg_cur = (col == '0) ? cfg : cfg_q;

    always_comb begin
        case (cfg_cur.mode)
            mirror_pkg::MODE_MIRROR:  take_rev = 1'b1;
            mirror_pkg::MODE_KALEIDO: take_rev = (col >= mirror_pkg::HALF_COL);
            default:                  take_rev = 1'b0;
        endcase
    end

    assign sel_data = take_rev ? rev_pix.data : fwd_pix.data;
    assign swp_data = cfg_cur.swap ? {sel_data[7:0], sel_data[15:8]} : sel_data;

    always_ff @(posedge clk) begin
        if (fwd_pix.valid) begin
            out_data <= swp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col       <= '0;
            cfg_q     <= mirror_pkg::CFG_RESET;
            out_valid <= 1'b0;
            line_done <= 1'b0;
        end else begin
            out_valid <= fwd_pix.valid;
            line_done <= fwd_pix.valid && (col == mirror_pkg::LAST_COL);
            if (fwd_pix.valid) begin
                col <= (col == mirror_pkg::LAST_COL) ? '0 : col + 1'b1;
                if (col == '0) begin
                    cfg_q <= cfg;
                end
            end
        end
    end

    assign pix_out.valid = out_valid;
    assign pix_out.data = out_data;

endmodule

// File: rtl/line_delay.sv
`timescale 1ns/1ps

module line_delay (
    input  logic               clk,
    input  logic               rst,
    input  mirror_pkg::pixel_t pix_in,
    output mirror_pkg::pixel_t pix_out
);

    logic [15:0] mem0 [mirror_pkg::LINE_WIDTH];
    logic [15:0] mem1 [mirror_pkg::LINE_WIDTH];

    logic [mirror_pkg::PTR_BITS-1:0] wr_ptr;
    logic [mirror_pkg::PTR_BITS-1:0] rd_ptr;
    logic                            wr_sel;
    logic                            rd_sel;
    logic                            full0;
    logic                            full1;
    logic                            rd_full;
    logic                            wr_last;
    logic                            rd_last;
    logic                            rd_valid;
    logic [15:0]                     rd_data;
    logic                            out_valid;
    logic [15:0]                     out_data;

    assign rd_sel = ~wr_sel;
    assign rd_full = rd_sel ? full1 : full0;
    assign wr_last = pix_in.valid && (wr_ptr == mirror_pkg::LAST_COL);
    assign rd_last = rd_full && (rd_ptr == mirror_pkg::LAST_COL);

    always_ff @(posedge clk) begin
        if (pix_in.valid) begin
            if (wr_sel) begin
                mem1[wr_ptr] <= pix_in.data;
            end else begin
                mem0[wr_ptr] <= pix_in.data;
            end
        end
    end

    // Same two-stage read path as line_reverse so both outputs stay in step
    always_ff @(posedge clk) begin
        if (rd_full) begin
            rd_data <= rd_sel ? mem1[rd_ptr] : mem0[rd_ptr];
        end
        out_data <= rd_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            wr_sel    <= 1'b0;
            full0     <= 1'b0;
            full1     <= 1'b0;
            rd_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            rd_valid  <= rd_full;
            out_valid <= rd_valid;

            if (pix_in.valid) begin
                wr_ptr <= wr_last ? '0 : wr_ptr + 1'b1;
            end
            if (wr_last) begin
                wr_sel <= ~wr_sel;
            end
            if (rd_full) begin
                rd_ptr <= rd_last ? '0 : rd_ptr + 1'b1;
            end

            // A completed write never targets the memory being drained
            if (rd_last) begin
                if (rd_sel) begin
                    full1 <= 1'b0;
                end else begin
                    full0 <= 1'b0;
                end
            end
            if (wr_last) begin
                if (wr_sel) begin
                    full1 <= 1'b1;
                end else begin
                    full0 <= 1'b1;
                end
            end
        end
    end

    assign pix_out.valid = out_valid;
    assign pix_out.data = out_data;

endmodule

// File: rtl/line_reverse.sv
`timescale 1ns/1ps

module line_reverse (
    input  logic               clk,
    input  logic               rst,
    input  mirror_pkg::pixel_t pix_in,
    output mirror_pkg::pixel_t pix_out
);

    logic [15:0] mem0 [mirror_pkg::LINE_WIDTH];
    logic [15:0] mem1 [mirror_pkg::LINE_WIDTH];

    logic [mirror_pkg::PTR_BITS-1:0] wr_ptr;
    logic [mirror_pkg::PTR_BITS-1:0] rd_ptr;
    logic                            wr_sel;
    logic                            rd_sel;
    logic                            full0;
    logic                            full1;
    logic                            rd_full;
    logic                            wr_last;
    logic                            rd_last;
    logic                            rd_valid;
    logic [15:0]                     rd_data;
    logic                            out_valid;
    logic [15:0]                     out_data;

    // The memory not being written is the one being replayed
    assign rd_sel = ~wr_sel;
    assign rd_full = rd_sel ? full1 : full0;
    assign wr_last = pix_in.valid && (wr_ptr == mirror_pkg::LAST_COL);
    assign rd_last = rd_full && (rd_ptr == '0);

    always_ff @(posedge clk) begin
        if (pix_in.valid) begin
            if (wr_sel) begin
                mem1[wr_ptr] <= pix_in.data;
            end else begin
                mem0[wr_ptr] <= pix_in.data;
            end
        end
    end

    // Read stage, then an output register, so beat 0 leaves two edges after the line fills
    always_ff @(posedge clk) begin
        if (rd_full) begin
            rd_data <= rd_sel ? mem1[rd_ptr] : mem0[rd_ptr];
        end
        out_data <= rd_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= mirror_pkg::LAST_COL;
            wr_sel    <= 1'b0;
            full0     <= 1'b0;
            full1     <= 1'b0;
            rd_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            rd_valid  <= rd_full;
            out_valid <= rd_valid;

            if (pix_in.valid) begin
                wr_ptr <= wr_last ? '0 : wr_ptr + 1'b1;
            end
            if (wr_last) begin
                wr_sel <= ~wr_sel;
            end

            // Columns are replayed from the right edge back to column 0
            if (rd_full) begin
                rd_ptr <= rd_last ? mirror_pkg::LAST_COL : rd_ptr - 1'b1;
            end

            if (rd_last && !rd_sel) begin
                full0 <= 1'b0;
            end
            if (rd_last && rd_sel) begin
                full1 <= 1'b0;
            end
            if (wr_last && !wr_sel) begin
                full0 <= 1'b1;
            end
            if (wr_last && wr_sel) begin
                full1 <= 1'b1;
            end
        end
    end

    assign pix_out.valid = out_valid;
    assign pix_out.data = out_data;

endmodule

// File: rtl/mirror_pkg.sv
package mirror_pkg;

    // Pixels per line, must be even
    localparam int unsigned LINE_WIDTH = 16;

    localparam int unsigned PTR_BITS = $clog2(LINE_WIDTH);

    // Column indices used by the buffers and the combiner
    localparam logic [PTR_BITS-1:0] LAST_COL = PTR_BITS'(LINE_WIDTH - 1);
    localparam logic [PTR_BITS-1:0] HALF_COL = PTR_BITS'(LINE_WIDTH / 2);

    // APB byte addresses
    localparam logic [7:0] ADDR_CTRL = 8'h00;
    localparam logic [7:0] ADDR_STATUS = 8'h04;

    // One beat of the RGB565 stream
    typedef struct packed {
        logic        valid;
        logic [15:0] data;
    } pixel_t;

    // MODE_RSVD is treated like MODE_PASS
    typedef enum logic [1:0] {
        MODE_PASS    = 2'd0,
        MODE_MIRROR  = 2'd1,
        MODE_KALEIDO = 2'd2,
        MODE_RSVD    = 2'd3
    } compose_mode_e;

    typedef struct packed {
        compose_mode_e mode;
        logic          swap;
    } mirror_cfg_t;

    // Configuration after reset: pass through with the byte swap on
    localparam mirror_cfg_t CFG_RESET = '{
        mode: MODE_PASS,
        swap: 1'b1
    };

endpackage

// File: rtl/mirror_regs.sv
`timescale 1ns/1ps

module mirror_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [7:0]              paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    line_done,
    output mirror_pkg::mirror_cfg_t cfg
);

    logic                    access;
    logic                    ctrl_hit;
    logic                    status_hit;
    mirror_pkg::mirror_cfg_t cfg_q;
    logic [15:0]             line_count;

    assign access = psel && penable;
    assign ctrl_hit = (paddr == mirror_pkg::ADDR_CTRL);
    assign status_hit = (paddr == mirror_pkg::ADDR_STATUS);

    // No wait states
    assign pready = 1'b1;
    assign pslverr = access && !(ctrl_hit || status_hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= mirror_pkg::CFG_RESET;
        end else if (access && pwrite && ctrl_hit) begin
            cfg_q.mode <= mirror_pkg::compose_mode_e'(pwdata[1:0]);
            cfg_q.swap <= pwdata[4];
        end
    end

    // Output line counter, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            line_count <= '0;
        end else if (line_done) begin
            line_count <= line_count + 16'd1;
        end
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            if (ctrl_hit) begin
                prdata[1:0] = cfg_q.mode;
                prdata[4]   = cfg_q.swap;
            end else if (status_hit) begin
                prdata[15:0] = line_count;
            end
        end
    end

    assign cfg = cfg_q;

endmodule

// File: rtl/mirror_top.sv
`timescale 1ns/1ps

module mirror_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  mirror_pkg::pixel_t pix_in,
    output mirror_pkg::pixel_t pix_out
);

    mirror_pkg::mirror_cfg_t cfg;
    mirror_pkg::pixel_t      rev_pix;
    mirror_pkg::pixel_t      fwd_pix;
    logic                    line_done;

    mirror_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .line_done (line_done),
        .cfg       (cfg)
    );

    // Both buffers take the same input so their bursts line up
    line_reverse u_reverse (
        .clk     (clk),
        .rst     (rst),
        .pix_in  (pix_in),
        .pix_out (rev_pix)
    );

    line_delay u_delay (
        .clk     (clk),
        .rst     (rst),
        .pix_in  (pix_in),
        .pix_out (fwd_pix)
    );

    line_compose u_compose (
        .clk       (clk),
        .rst       (rst),
        .fwd_pix   (fwd_pix),
        .rev_pix   (rev_pix),
        .cfg       (cfg),
        .pix_out   (pix_out),
        .line_done (line_done)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the mirror testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module mirror_tb -o mirror_sim

# The log decides the result, so a stopped run still reaches the search
./obj_dir/mirror_sim 2>&1 | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run_sim: pass message found"
    exit 0
fi
echo "run_sim: pass message not found in sim.log"
exit 1

// File: test/mirror_props.sv
`timescale 1ns/1ps

module mirror_props (
    input logic               clk,
    input logic               rst,
    input mirror_pkg::pixel_t fwd_pix,
    input mirror_pkg::pixel_t rev_pix,
    input mirror_pkg::pixel_t pix_out,
    input logic               line_done
);

    int unsigned run_len;

    // Consecutive output beats seen in the current burst
    always_ff @(posedge clk) begin
        if (rst) begin
            run_len <= 0;
        end else if (pix_out.valid) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    a_valid_match: assert property (@(posedge clk) disable iff (rst)
        fwd_pix.valid == rev_pix.valid)
        else $error("forward and reversed beats are not valid in the same cycle");

    a_line_length: assert property (@(posedge clk) disable iff (rst)
        !pix_out.valid && run_len != 0 |-> run_len % mirror_pkg::LINE_WIDTH == 0)
        else $error("output burst ended partway through a line");

    a_no_gap: assert property (@(posedge clk) disable iff (rst)
        pix_out.valid && !line_done |=> pix_out.valid)
        else $error("gap inside an output line");

    a_done_beat: assert property (@(posedge clk) disable iff (rst)
        line_done |-> pix_out.valid && (run_len + 1) % mirror_pkg::LINE_WIDTH == 0)
        else $error("line_done pulsed away from the last beat of an output line");

endmodule

bind line_compose mirror_props u_props (
    .clk       (clk),
    .rst       (rst),
    .fwd_pix   (fwd_pix),
    .rev_pix   (rev_pix),
    .pix_out   (pix_out),
    .line_done (line_done)
);

// File: test/mirror_tb.sv
`timescale 1ns/1ps

module mirror_tb;

    logic               clk = 1'b0;
    logic               rst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [7:0]         paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    mirror_pkg::pixel_t pix_in;
    mirror_pkg::pixel_t pix_out;

    logic [15:0] line_buf [mirror_pkg::LINE_WIDTH];
    logic [15:0] out_pix [$];
    logic [15:0] exp_pix [$];
    int unsigned line_start [$];
    int unsigned last_in [$];
    int unsigned cycle = 0;
    int          width = int'(mirror_pkg::LINE_WIDTH);
    int          beat_cnt = 0;
    int          lines_sent = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_errors = 0;

    mirror_top DUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Output beats are taken on the falling edge, where pix_out is settled
    always @(negedge clk) begin
        if (!rst && pix_out.valid) begin
            if (beat_cnt == 0) begin
                line_start.push_back(cycle);
            end
            out_pix.push_back(pix_out.data);
            beat_cnt = (beat_cnt == width - 1) ? 0 : beat_cnt + 1;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", what, got, exp);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err = pslverr;
        // Every transfer completes without wait states
        check_value("pready", 32'(pready), 1);
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // Reference model: new random line, expected output appended per column
    function automatic void fill_line(input mirror_pkg::compose_mode_e mode, input logic swap);
        int          src;
        logic [15:0] p;
        for (int i = 0; i < width; i++) begin
            line_buf[i] = 16'($urandom);
        end
        for (int c = 0; c < width; c++) begin
            src = c;
            if (mode == mirror_pkg::MODE_MIRROR ||
                (mode == mirror_pkg::MODE_KALEIDO && c >= width / 2)) begin
                src = width - 1 - c;
            end
            p = line_buf[src];
            exp_pix.push_back(swap ? {p[7:0], p[15:8]} : p);
        end
    endfunction

    task automatic send_line(input bit gaps);
        for (int i = 0; i < width; i++) begin
            if (gaps && i > 0 && $urandom_range(2, 0) == 0) begin
                @(posedge clk);
                #1;
                pix_in.valid = 1'b0;
            end
            @(posedge clk);
            #1;
            pix_in.valid = 1'b1;
            pix_in.data = line_buf[i];
        end
        // The last beat is captured on the coming edge
        last_in.push_back(cycle + 1);
        lines_sent++;
    endtask

    task automatic stream_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            pix_in.valid = 1'b0;
        end
    endtask

    task automatic collect(input int lines);
        int waited;
        waited = 0;
        while (out_pix.size() < lines * width && waited < lines * (2 * width + 20)) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);
        checks++;
        if (out_pix.size() != lines * width) begin
            errors++;
            $display("Expected %0d output beats but saw %0d", lines * width, out_pix.size());
        end
        for (int i = 0; i < out_pix.size() && i < exp_pix.size(); i++) begin
            check_value($sformatf("pix_out.data line %0d col %0d", i / width, i % width),
                        32'(out_pix[i]), 32'(exp_pix[i]));
        end
    endtask

    task automatic begin_test();
        out_pix.delete();
        exp_pix.delete();
        line_start.delete();
        last_in.delete();
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - test_errors);
        end
    endtask

    task automatic test_reset_defaults();
        logic [31:0] data;
        logic        err;
        begin_test();
        check_value("pix_out.valid", 32'(pix_out.valid), 0);
        apb_read(mirror_pkg::ADDR_CTRL, data, err);
        check_value("prdata at ADDR_CTRL", data, 32'h10);
        check_value("pslverr at ADDR_CTRL", 32'(err), 0);
        apb_read(mirror_pkg::ADDR_STATUS, data, err);
        check_value("prdata at ADDR_STATUS", data, 0);
        apb_read(8'h08, data, err);
        check_value("pslverr at 0x08", 32'(err), 1);
        finish_test("reset_defaults");
    endtask

    task automatic test_pass_swap();
        begin_test();
        for (int l = 0; l < 2; l++) begin
            fill_line(mirror_pkg::MODE_PASS, 1'b1);
            send_line(1'b1);
            stream_idle(2);
        end
        collect(2);
        for (int l = 0; l < line_start.size() && l < last_in.size(); l++) begin
            check_value($sformatf("latency of line %0d", l), line_start[l] - last_in[l], 3);
        end
        finish_test("pass_swap");
    endtask

    task automatic test_mirror_back_to_back();
        begin_test();
        apb_write(mirror_pkg::ADDR_CTRL, 32'h01);
        for (int l = 0; l < 3; l++) begin
            fill_line(mirror_pkg::MODE_MIRROR, 1'b0);
            send_line(1'b0);
        end
        stream_idle(2);
        collect(3);
        for (int l = 1; l < line_start.size(); l++) begin
            check_value($sformatf("start spacing of line %0d", l),
                        line_start[l] - line_start[l - 1], width);
        end
        finish_test("mirror_back_to_back");
    endtask

    task automatic test_kaleido();
        int c;
        int m;
        begin_test();
        apb_write(mirror_pkg::ADDR_CTRL, 32'h12);
        for (int l = 0; l < 2; l++) begin
            fill_line(mirror_pkg::MODE_KALEIDO, 1'b1);
            send_line(1'b1);
            stream_idle(2);
        end
        collect(2);
        // The right half must hold the left half's expected pixels in reverse order
        for (int i = 0; i < out_pix.size() && i < exp_pix.size(); i++) begin
            c = i % width;
            m = i - c + width - 1 - c;
            if (c < width / 2 && m < out_pix.size()) begin
                check_value($sformatf("pix_out.data mirror of col %0d", c),
                            32'(out_pix[m]), 32'(exp_pix[i]));
            end
        end
        finish_test("kaleido");
    endtask

    task automatic test_mode_change();
        logic [31:0] data;
        logic        err;
        begin_test();
        apb_write(mirror_pkg::ADDR_CTRL, 32'h01);
        fill_line(mirror_pkg::MODE_MIRROR, 1'b0);
        fork
            begin
                send_line(1'b0);
                fill_line(mirror_pkg::MODE_KALEIDO, 1'b1);
                send_line(1'b0);
                stream_idle(2);
            end
            begin
                // Change the mode while the first line is on the output
                while (out_pix.size() < 4) @(posedge clk);
                apb_write(mirror_pkg::ADDR_CTRL, 32'h12);
            end
        join
        collect(2);
        apb_read(mirror_pkg::ADDR_STATUS, data, err);
        check_value("prdata at ADDR_STATUS", data, 32'(lines_sent));
        finish_test("mode_change");
    endtask

    initial begin
        void'($urandom(5));
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pix_in = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_defaults();
        test_pass_swap();
        test_mirror_back_to_back();
        test_kaleido();
        test_mode_change();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Five tests of at most three lines each
    initial begin
        int limit;
        limit = 5 * 3 * (2 * width + 20);
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
